/* hdl/boot_rom.sv */
// Boot ROM holding the package image
// Registered read, data appears the cycle after req_i and holds until the next request

module boot_rom import bus_pkg::*, soc_pkg::*; (
  input  logic     clk_i,
  input  logic     req_i,
  input  rom_idx_t addr_i,
  output data_t    rdata_o
);

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rom_image[addr_i];
    end
  end

endmodule

/* hdl/bus2mem.sv */
// Read bus to ROM adapter with a single response slot
// Addresses outside the ROM answer DECERR with zero data; the low two address bits are ignored

module bus2mem import bus_pkg::*, soc_pkg::*; #(
  parameter bit StallRandom = 1'b0
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  rd_bus_if.slave  bus,
  output logic     rom_req_o,
  output rom_idx_t rom_addr_o,
  input  data_t    rom_rdata_i
);

  logic  resp_valid_q;
  resp_e resp_code_q;
  data_t resp_data_q;
  logic  rom_fresh_q;

  addr_t offset;
  logic  in_range;
  logic  stall;
  logic  ar_fire;
  logic  r_fire;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  // Unsigned wrap makes addresses below the base fail the compare too
  assign offset   = bus.ar_addr - RomBase;
  assign in_range = (offset < addr_t'(RomWords * 4));

  assign rom_addr_o = offset[RomIdxWidth+1:2];
  assign rom_req_o  = ar_fire && in_range;

  // ----------------------------------------------------------
  // Handshakes
  // ----------------------------------------------------------
  // Free slot, or the pending response leaves this cycle
  assign bus.ar_ready = (!resp_valid_q || r_fire) && !stall;
  assign ar_fire      = bus.ar_valid && bus.ar_ready;
  assign r_fire       = resp_valid_q && bus.r_ready;

  assign bus.r_valid = resp_valid_q;
  assign bus.r_resp  = resp_code_q;
  // ROM output is used directly in the cycle after the request
  assign bus.r_data  = rom_fresh_q ? rom_rdata_i : resp_data_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
      resp_code_q  <= OKAY;
      rom_fresh_q  <= 1'b0;
    end else begin
      rom_fresh_q <= rom_req_o;
      if (ar_fire) begin
        resp_valid_q <= 1'b1;
        resp_code_q  <= in_range ? OKAY : DECERR;
      end else if (r_fire) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  // Keep ROM data once its cycle is over, in case the read channel stalls
  always_ff @(posedge clk_i) begin
    if (rom_fresh_q) begin
      resp_data_q <= rom_rdata_i;
    end
    if (ar_fire && !in_range) begin
      resp_data_q <= '0;
    end
  end

  // ----------------------------------------------------------
  // Random stalls
  // ----------------------------------------------------------
  if (StallRandom) begin : g_stall
    logic [15:0] lfsr_q;

    // x^16 + x^14 + x^13 + x^11
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        lfsr_q <= 16'hace1;
      end else begin
        lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      end
    end

    assign stall = lfsr_q[0];
  end else begin : g_no_stall
    assign stall = 1'b0;
  end

endmodule

/* hdl/bus_pkg.sv */
// Read-only bus definitions shared by the fetch master and the bus adapter
// Byte addressing with 32-bit words, so the two low address bits are ignored

package bus_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // Byte address on the address channel
  typedef logic [AddrWidth-1:0] addr_t;

  // One data word on the read channel
  typedef logic [DataWidth-1:0] data_t;

  // Number of words in a fetch run
  typedef logic [15:0] count_t;

  // ----------------------------------------------------------
  // Read response
  // ----------------------------------------------------------
  // DECERR when the address hits no memory, the data word is then zero
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } resp_e;

endpackage

/* hdl/fetch_harness.sv */
// Boot-fetch harness: reset synchronizer, fetch master, bus adapter and boot ROM
// Only the ROM is mapped; start_i is taken only while the master is idle

module fetch_harness import bus_pkg::*, soc_pkg::*; #(
  parameter int unsigned MaxOutstanding = 2,
  parameter bit          StallRandom    = 1'b0,
  parameter int unsigned ResetHold      = 4
) (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   start_i,
  input  addr_t  start_addr_i,
  input  count_t count_i,
  output logic   instr_valid_o,
  output data_t  instr_o,
  output addr_t  instr_addr_o,
  output logic   done_o,
  output data_t  exit_o,
  output logic   error_o
);

  logic     core_rst_n;
  logic     rom_req;
  rom_idx_t rom_addr;
  data_t    rom_rdata;

  rd_bus_if bus ();

  // ----------------------------------------------------------
  // Reset
  // ----------------------------------------------------------
  rst_sync #(
    .ResetHold ( ResetHold )
  ) i_rst_sync (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .rst_n_o ( core_rst_n )
  );

  // ----------------------------------------------------------
  // Core side
  // ----------------------------------------------------------
  fetch_master #(
    .MaxOutstanding ( MaxOutstanding )
  ) i_fetch_master (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( core_rst_n    ),
    .start_i       ( start_i       ),
    .start_addr_i  ( start_addr_i  ),
    .count_i       ( count_i       ),
    .bus           ( bus.master    ),
    .instr_valid_o ( instr_valid_o ),
    .instr_o       ( instr_o       ),
    .instr_addr_o  ( instr_addr_o  ),
    .done_o        ( done_o        ),
    .exit_o        ( exit_o        ),
    .error_o       ( error_o       )
  );

  // ----------------------------------------------------------
  // ROM
  // ----------------------------------------------------------
  bus2mem #(
    .StallRandom ( StallRandom )
  ) i_bus2rom (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( core_rst_n ),
    .bus         ( bus.slave  ),
    .rom_req_o   ( rom_req    ),
    .rom_addr_o  ( rom_addr   ),
    .rom_rdata_i ( rom_rdata  )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .addr_i  ( rom_addr  ),
    .rdata_o ( rom_rdata )
  );

endmodule

/* hdl/fetch_master.sv */
// Fetch master, reads count_i words from start_addr_i and streams them out
// Up to MaxOutstanding reads in flight; exit_o is the XOR of all words of a run

module fetch_master import bus_pkg::*, soc_pkg::*; #(
  parameter int unsigned MaxOutstanding = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     start_i,
  input  addr_t    start_addr_i,
  input  count_t   count_i,
  rd_bus_if.master bus,
  output logic     instr_valid_o,
  output data_t    instr_o,
  output addr_t    instr_addr_o,
  output logic     done_o,
  output data_t    exit_o,
  output logic     error_o
);

  localparam int unsigned OutWidth = $clog2(MaxOutstanding + 1);

  typedef logic [OutWidth-1:0] out_cnt_t;

  localparam out_cnt_t OutMax = out_cnt_t'(MaxOutstanding);

  fetch_state_e state_q;
  count_t       total_q;
  count_t       issued_q;
  count_t       received_q;
  out_cnt_t     outstanding_q;
  addr_t        issue_addr_q;
  addr_t        resp_addr_q;
  data_t        checksum_q;
  logic         err_q;

  logic ar_fire;
  logic r_fire;
  logic r_err;
  logic last_issue;
  logic last_resp;

  // ----------------------------------------------------------
  // Bus side
  // ----------------------------------------------------------
  // Valid only depends on state and counters, so it holds while stalled
  assign bus.ar_valid = (state_q == RUN) && (outstanding_q < OutMax);
  assign bus.ar_addr  = issue_addr_q;
  assign bus.r_ready  = 1'b1;

  assign ar_fire    = bus.ar_valid && bus.ar_ready;
  assign r_fire     = bus.r_valid && bus.r_ready;
  assign r_err      = (bus.r_resp == DECERR);
  assign last_issue = ((issued_q + count_t'(1)) == total_q);
  assign last_resp  = ((received_q + count_t'(1)) == total_q);

  // ----------------------------------------------------------
  // Control
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q       <= IDLE;
      total_q       <= '0;
      issued_q      <= '0;
      received_q    <= '0;
      outstanding_q <= '0;
      checksum_q    <= '0;
      err_q         <= 1'b0;
      instr_valid_o <= 1'b0;
      done_o        <= 1'b0;
      exit_o        <= '0;
      error_o       <= 1'b0;
    end else begin
      done_o        <= 1'b0;
      instr_valid_o <= r_fire;

      case (state_q)
        IDLE: begin
          if (start_i) begin
            total_q    <= count_i;
            issued_q   <= '0;
            received_q <= '0;
            checksum_q <= '0;
            err_q      <= 1'b0;
            // Empty run finishes at once
            if (count_i == '0) begin
              done_o  <= 1'b1;
              exit_o  <= '0;
              error_o <= 1'b0;
            end else begin
              state_q <= RUN;
            end
          end
        end
        RUN: begin
          if (ar_fire) begin
            issued_q <= issued_q + count_t'(1);
            if (last_issue) begin
              state_q <= DRAIN;
            end
          end
        end
        DRAIN: begin
          if (r_fire && last_resp) begin
            state_q <= IDLE;
            done_o  <= 1'b1;
            exit_o  <= checksum_q ^ bus.r_data;
            error_o <= err_q | r_err;
          end
        end
        default: state_q <= IDLE;
      endcase

      // Response accounting, the same in RUN and DRAIN
      if (r_fire) begin
        received_q <= received_q + count_t'(1);
        checksum_q <= checksum_q ^ bus.r_data;
        err_q      <= err_q | r_err;
      end

      case ({ar_fire, r_fire})
        2'b10:   outstanding_q <= outstanding_q + out_cnt_t'(1);
        2'b01:   outstanding_q <= outstanding_q - out_cnt_t'(1);
        default: outstanding_q <= outstanding_q;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Address and data path
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && start_i) begin
      issue_addr_q <= start_addr_i;
      resp_addr_q  <= start_addr_i;
    end else begin
      if (ar_fire) begin
        issue_addr_q <= issue_addr_q + addr_t'(4);
      end
      if (r_fire) begin
        resp_addr_q <= resp_addr_q + addr_t'(4);
      end
    end
    if (r_fire) begin
      instr_o      <= bus.r_data;
      instr_addr_o <= resp_addr_q;
    end
  end

endmodule

/* hdl/rd_bus_if.sv */
// Read-only valid/ready bus with an address channel and a read channel
// Responses come back in request order, there are no IDs

interface rd_bus_if import bus_pkg::*; ();

  // Address channel
  logic  ar_valid;
  logic  ar_ready;
  addr_t ar_addr;

  // Read channel
  logic  r_valid;
  logic  r_ready;
  data_t r_data;
  resp_e r_resp;

  modport master (
    output ar_valid,
    output ar_addr,
    input  ar_ready,
    input  r_valid,
    input  r_data,
    input  r_resp,
    output r_ready
  );

  modport slave (
    input  ar_valid,
    input  ar_addr,
    output ar_ready,
    output r_valid,
    output r_data,
    output r_resp,
    input  r_ready
  );

endinterface

/* hdl/rst_sync.sv */
// Reset synchronizer with a stretched release
// Assertion follows the input at the next edge, release lags it by ResetHold + 2 cycles

module rst_sync #(
  parameter int unsigned ResetHold = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic rst_n_o
);

  localparam int unsigned CntWidth = (ResetHold > 0) ? $clog2(ResetHold + 1) : 1;
  localparam logic [CntWidth-1:0] HoldVal = CntWidth'(ResetHold);

  logic                sync1_q;
  logic                sync2_q;
  logic [CntWidth-1:0] hold_cnt_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q    <= 1'b0;
      sync2_q    <= 1'b0;
      hold_cnt_q <= '0;
      rst_n_o    <= 1'b0;
    end else begin
      // Two-flop synchronizer
      sync1_q <= 1'b1;
      sync2_q <= sync1_q;
      // Hold counter runs once the synchronized release is seen
      if (sync2_q && (hold_cnt_q != HoldVal)) begin
        hold_cnt_q <= hold_cnt_q + 1'b1;
      end
      rst_n_o <= sync2_q && (hold_cnt_q == HoldVal);
    end
  end

endmodule

/* hdl/soc_pkg.sv */
// Memory map and boot image of the harness
// The ROM is the only target on the bus, any other address decodes to an error

package soc_pkg;

  // ----------------------------------------------------------
  // Memory map
  // ----------------------------------------------------------
  localparam bus_pkg::addr_t RomBase     = 32'h0001_0000;
  localparam int unsigned    RomWords    = 64;
  localparam int unsigned    RomIdxWidth = $clog2(RomWords);

  // Word index into the ROM
  typedef logic [RomIdxWidth-1:0] rom_idx_t;

  // ----------------------------------------------------------
  // Boot image, word 0 sits at RomBase
  // ----------------------------------------------------------
  localparam bus_pkg::data_t rom_image [RomWords] = '{
    32'h0000_0297, 32'h0202_8593, 32'hf140_2573, 32'h0182_b283,
    32'h0002_8067, 32'h0000_0013, 32'h1050_0073, 32'hffdf_f06f,
    32'h0010_0513, 32'h00a0_0593, 32'h00b5_0633, 32'h40a5_86b3,
    32'h00c6_f733, 32'h00d7_67b3, 32'h00e7_c833, 32'h0015_1893,
    32'h0015_d913, 32'h4015_d993, 32'h00c5_2a23, 32'h0145_2a03,
    32'h00a5_a463, 32'hfe05_88e3, 32'h00b5_1463, 32'h0100_006f,
    32'h1234_5537, 32'h6785_0513, 32'h0000_0597, 32'h00c5_8593,
    32'h0005_a603, 32'h0046_0613, 32'h00c5_a023, 32'hfe06_1ce3,
    32'h3004_7073, 32'h3401_1073, 32'h3052_9073, 32'h0000_8067,
    32'h7ff0_0713, 32'h8000_07b7, 32'hfff7_8793, 32'h00f7_7833,
    32'h02a5_c533, 32'h02b5_4633, 32'h02c5_e6b3, 32'h02d6_7733,
    32'h0000_1117, 32'hff01_0113, 32'h0011_2623, 32'h0081_2423,
    32'h0101_0413, 32'h00c1_2083, 32'h0081_2403, 32'h0101_0113,
    32'hdead_beef, 32'hcafe_f00d, 32'h0bad_c0de, 32'h8bad_f00d,
    32'h1357_9bdf, 32'h2468_ace0, 32'ha5a5_a5a5, 32'h5a5a_5a5a,
    32'h0f0f_0f0f, 32'hf0f0_f0f0, 32'h00ff_00ff, 32'hc001_d00d
  };

  // ----------------------------------------------------------
  // Fetch master FSM
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } fetch_state_e;

endpackage

/* tb.f */
hdl/bus_pkg.sv
hdl/soc_pkg.sv
hdl/rd_bus_if.sv
hdl/rst_sync.sv
hdl/fetch_master.sv
hdl/bus2mem.sv
hdl/boot_rom.sv
hdl/fetch_harness.sv
tb/tb_fetch_harness.sv

/* tb/tb_fetch_harness.sv */
// Table-driven testbench for the boot-fetch harness with random stalls in the adapter
// Expected words come from rom_image and addresses outside the ROM read as zero
// Start addresses in the table are word aligned

module tb_fetch_harness import bus_pkg::*, soc_pkg::*; ;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned Timeout    = 2000;
  localparam int unsigned NumEntries = 10;
  localparam logic [31:0] Seed       = 32'h5e59_9fcc;

  typedef struct packed {
    addr_t  addr;
    count_t cnt;
    logic   err;
    logic   poke;
  } entry_t;

  logic   clk_i;
  logic   rst_n_i;
  logic   start_i;
  addr_t  start_addr_i;
  count_t count_i;
  logic   instr_valid_o;
  data_t  instr_o;
  addr_t  instr_addr_o;
  logic   done_o;
  data_t  exit_o;
  logic   error_o;

  int unsigned mism_cnt;
  int unsigned err_cnt;
  logic [31:0] rng_state;
  logic        timed_out;
  data_t       last_exit;
  logic        last_err;

  // ----------------------------------------------------------
  // Each entry holds start address, count, expected error and a mid-run start pulse
  // ----------------------------------------------------------
  entry_t tbl [NumEntries] = '{
    '{RomBase,                 16'd64, 1'b0, 1'b0},
    '{RomBase + 32'h10,        16'd5,  1'b0, 1'b0},
    '{RomBase + 32'h44,        16'd7,  1'b0, 1'b0},
    '{RomBase + 32'h9c,        16'd3,  1'b0, 1'b0},
    '{RomBase + 32'he0,        16'd8,  1'b0, 1'b0},
    '{RomBase + 32'hf0,        16'd8,  1'b1, 1'b0},
    '{RomBase,                 16'd0,  1'b0, 1'b0},
    '{RomBase + 32'h20,        16'd12, 1'b0, 1'b1},
    '{32'h0000_0100,           16'd3,  1'b1, 1'b0},
    '{RomBase + 32'h08,        16'd1,  1'b0, 1'b0}
  };

  fetch_harness #(
    .MaxOutstanding ( 2    ),
    .StallRandom    ( 1'b1 )
  ) DUT (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .start_i       ( start_i       ),
    .start_addr_i  ( start_addr_i  ),
    .count_i       ( count_i       ),
    .instr_valid_o ( instr_valid_o ),
    .instr_o       ( instr_o       ),
    .instr_addr_o  ( instr_addr_o  ),
    .done_o        ( done_o        ),
    .exit_o        ( exit_o        ),
    .error_o       ( error_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Reference model and helpers
  // ----------------------------------------------------------
  // ROM spans RomWords words starting at RomBase
  function automatic data_t model_word(input addr_t a);
    if ((a >= RomBase) && (a < RomBase + addr_t'(RomWords * 4))) begin
      return rom_image[int'((a - RomBase) / 4)];
    end
    return '0;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
      mism_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
      mism_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
      mism_cnt++;
    end
  endtask

  // Quiet cycles where the results of the last run must hold
  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      start_i <= 1'b0;
      @(negedge clk_i);
      check_bit("instr_valid_o", 1'b0, instr_valid_o);
      check_bit("done_o", 1'b0, done_o);
      check_bit("error_o", last_err, error_o);
      check_data("exit_o", last_exit, exit_o);
    end
  endtask

  task automatic run_entry(input int idx);
    entry_t      e;
    addr_t       exp_addr;
    data_t       exp_sum;
    int unsigned got;
    int unsigned cyc;
    int unsigned quiet;
    logic        done_seen;
    e       = tbl[idx];
    exp_sum = '0;
    for (int k = 0; k < int'(e.cnt); k++) begin
      exp_sum = exp_sum ^ model_word(e.addr + addr_t'(k * 4));
    end
    @(posedge clk_i);
    start_i      <= 1'b1;
    start_addr_i <= e.addr;
    count_i      <= e.cnt;
    got       = 0;
    cyc       = 0;
    quiet     = 0;
    done_seen = 1'b0;
    while (!done_seen && !timed_out) begin
      @(posedge clk_i);
      // Second start while busy with a different address and count
      start_i <= e.poke && (cyc == 2);
      if (e.poke && (cyc == 2)) begin
        start_addr_i <= 32'h0000_0040;
        count_i      <= 16'd3;
      end
      @(negedge clk_i);
      cyc++;
      quiet++;
      if (instr_valid_o) begin
        quiet = 0;
        if (got >= e.cnt) begin
          $display("Entry %0d: instr_valid_o pulsed after all %0d words arrived", idx, e.cnt);
          err_cnt++;
        end else begin
          exp_addr = e.addr + addr_t'(got * 4);
          check_addr("instr_addr_o", exp_addr, instr_addr_o);
          check_data("instr_o", model_word(exp_addr), instr_o);
        end
        got++;
      end
      if (done_o) begin
        done_seen = 1'b1;
        check_data("exit_o", exp_sum, exit_o);
        check_bit("error_o", e.err, error_o);
        if (got != e.cnt) begin
          $display("Entry %0d: done_o came after %0d words instead of %0d", idx, got, e.cnt);
          err_cnt++;
        end
        last_exit = exp_sum;
        last_err  = e.err;
      end else if (quiet >= Timeout) begin
        $display("Entry %0d: wait for instr_valid_o or done_o timed out", idx);
        err_cnt++;
        timed_out = 1'b1;
      end
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    rst_n_i      = 1'b0;
    start_i      = 1'b0;
    start_addr_i = '0;
    count_i      = '0;
    mism_cnt     = 0;
    err_cnt      = 0;
    rng_state    = Seed;
    timed_out    = 1'b0;
    last_exit    = '0;
    last_err     = 1'b0;

    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Outputs keep their reset values while the internal reset releases
    idle_cycles(16);

    for (int i = 0; i < int'(NumEntries) && !timed_out; i++) begin
      run_entry(i);
      rng_state = xorshift32(rng_state);
      if (!timed_out) begin
        idle_cycles(rng_state[2:0]);
      end
    end

    $display("Errors: %0d mismatches, %0d other failures", mism_cnt, err_cnt);
    if ((mism_cnt == 0) && (err_cnt == 0)) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
